/* tb.f */
+incdir+logic
logic/cpu_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/bus_select.sv
logic/control_unit.sv
logic/cpu_top.sv
bench/cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build the core with its testbench in Verilator and run the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f tb.f || exit 1
out=$(./obj_dir/Vcpu_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Test OK' && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}

/* bench/cpu_tb.sv */
// Testbench for the bus-based core: random instructions checked against a register model
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;

	import cpu_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int N_RAND = 60;
	// Zero reads, constant loads, directed cases, random ops with readback
	localparam int N_INSTR = 16 + 15 + 8 + 2 * N_RAND;
	localparam int WATCHDOG_CYCLES = N_INSTR * 20 + RESET_CYCLES;

	logic               clk;
	logic               rst_n;
	logic               req;
	instr_t             instr;
	logic               ack;
	logic [`CPU_DW-1:0] result;

	// Reference model state
	logic [`CPU_DW-1:0] model_regs [`CPU_NREG];
	logic [`CPU_DW-1:0] model_hi;
	logic [`CPU_DW-1:0] model_lo;

	integer seed;
	int     errors;
	int     checks;

	cpu_top dut (.clk(clk), .rst_n(rst_n), .req(req), .instr(instr),
		.ack(ack), .result(result));

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// Handshake order on the host port
	ack_rise_order: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> $past(req))
		else begin
			errors++;
			$display("ack rose at %0t although req was low", $time);
		end

	ack_fall_order: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(ack) |-> !$past(req))
		else begin
			errors++;
			$display("ack fell at %0t while req was still high", $time);
		end

	function automatic instr_t make_reg(input logic [4:0] op, input logic [3:0] ra,
		input logic [3:0] rb, input logic [3:0] rc);
		instr_t w;
		w = '0;
		w.r.opcode = op;
		w.r.ra = ra;
		w.r.rb = rb;
		w.r.rc = rc;
		return w;
	endfunction

	function automatic instr_t make_imm(input logic [4:0] op, input logic [3:0] ra,
		input logic [3:0] rb, input logic [18:0] c);
		instr_t w;
		w = '0;
		w.i.opcode = op;
		w.i.ra = ra;
		w.i.rb = rb;
		w.i.c = c;
		return w;
	endfunction

	task automatic check_eq(input string name, input logic [`CPU_DW-1:0] expected,
		input logic [`CPU_DW-1:0] actual);
		checks++;
		assert (actual === expected)
			else begin
				errors++;
				$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			end
	endtask

	// Model of one instruction, returns the value written to ra
	task automatic model_exec(input instr_t w, output logic [`CPU_DW-1:0] value);
		logic [`CPU_DW-1:0]   b_val;
		logic [`CPU_DW-1:0]   c_val;
		logic [`CPU_DW-1:0]   sext;
		logic [2*`CPU_DW-1:0] prod;
		b_val = model_regs[w.r.rb];
		c_val = model_regs[w.r.rc];
		sext = $signed(w.i.c);
		prod = {{`CPU_DW{b_val[`CPU_DW-1]}}, b_val} * {{`CPU_DW{c_val[`CPU_DW-1]}}, c_val};
		case (w.r.opcode)
			`OP_ADD:  value = b_val + c_val;
			`OP_SUB:  value = b_val - c_val;
			`OP_AND:  value = b_val & c_val;
			`OP_OR:   value = b_val | c_val;
			`OP_SHL:  value = b_val << c_val[4:0];
			`OP_SHR:  value = b_val >> c_val[4:0];
			`OP_NEG:  value = -c_val;
			`OP_NOT:  value = ~c_val;
			`OP_ADDI: value = b_val + sext;
			`OP_ANDI: value = b_val & sext;
			`OP_ORI:  value = b_val | sext;
			`OP_MFHI: value = model_hi;
			`OP_MFLO: value = model_lo;
			`OP_MUL: begin
				value = prod[`CPU_DW-1:0];
				model_hi = prod[2*`CPU_DW-1:`CPU_DW];
				model_lo = prod[`CPU_DW-1:0];
			end
			default:  value = '0;
		endcase
		model_regs[w.r.ra] = value;
	endtask

	// Four-phase handshake with random back-pressure
	task automatic send_instr(input instr_t w, output logic [`CPU_DW-1:0] value);
		int edges;
		int hold;
		@(posedge clk);
		req   <= 1'b1;
		instr <= w;
		// This negedge comes before the first edge that samples req
		@(negedge clk);
		edges = 0;
		while (!ack && edges < 20) begin
			@(negedge clk);
			edges++;
		end
		checks++;
		assert (edges == 5)
			else begin
				errors++;
				$display("ack came %0d cycles after req instead of 5", edges);
			end
		value = result;
		hold = $unsigned($random(seed)) % 6;
		repeat (hold) begin
			@(negedge clk);
			assert (ack)
				else begin
					errors++;
					$display("ack dropped at %0t while req was still held", $time);
				end
			check_eq("result", value, result);
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		edges = 0;
		while (ack && edges < 20) begin
			@(negedge clk);
			edges++;
		end
		checks++;
		assert (edges == 1)
			else begin
				errors++;
				$display("ack took %0d cycles to fall after req dropped", edges);
			end
	endtask

	task automatic run_check(input instr_t w);
		logic [`CPU_DW-1:0] expected;
		logic [`CPU_DW-1:0] got;
		model_exec(w, expected);
		send_instr(w, got);
		check_eq("result", expected, got);
	endtask

	initial begin
		logic [4:0] op;
		logic [3:0] ra;
		seed = 1548;
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		req = 1'b0;
		instr = '0;
		for (int i = 0; i < `CPU_NREG; i++) begin
			model_regs[i] = '0;
		end
		model_hi = '0;
		model_lo = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		// No ack before the first request
		repeat (4) begin
			@(negedge clk);
			assert (!ack)
				else begin
					errors++;
					$display("ack high at %0t with no request pending", $time);
				end
		end

		// Every register reads zero after reset
		for (int i = 0; i < `CPU_NREG; i++) begin
			run_check(make_reg(`OP_ADD, 4'(i), 4'(i), 4'd0));
		end

		// Random constants into r1..r15
		for (int i = 1; i < `CPU_NREG; i++) begin
			run_check(make_imm(`OP_ADDI, 4'(i), 4'd0, 19'($random(seed))));
		end

		// Negative constants, signed product and HI/LO moves
		run_check(make_imm(`OP_ADDI, 4'd1, 4'd0, 19'h7fffb));
		run_check(make_imm(`OP_ANDI, 4'd2, 4'd1, 19'h7ff0f));
		run_check(make_imm(`OP_ORI, 4'd3, 4'd0, 19'h40000));
		run_check(make_imm(`OP_ADDI, 4'd4, 4'd0, 19'd7));
		run_check(make_reg(`OP_MUL, 4'd5, 4'd1, 4'd4));
		run_check(make_reg(`OP_MFHI, 4'd6, 4'd0, 4'd0));
		run_check(make_reg(`OP_MFLO, 4'd7, 4'd0, 4'd0));
		run_check(make_reg(`OP_MUL, 4'd8, 4'd1, 4'd1));

		// Random ops, each followed by a readback of ra
		for (int n = 0; n < N_RAND; n++) begin
			op = 5'($unsigned($random(seed)) % 14);
			ra = 4'($random(seed));
			if (op == `OP_ADDI || op == `OP_ANDI || op == `OP_ORI) begin
				run_check(make_imm(op, ra, 4'($random(seed)), 19'($random(seed))));
			end else begin
				run_check(make_reg(op, ra, 4'($random(seed)), 4'($random(seed))));
			end
			run_check(make_reg(`OP_OR, ra, ra, ra));
		end

		repeat (2) @(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog sized from the instruction count
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired at %0t, the core stopped answering", $time);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Test FAILED");
		$finish;
	end

endmodule

/* logic/cpu_top.sv */
// Core top level: control unit, register file, bus, ALU and the Y and Z registers
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                req,
	input  cpu_pkg::instr_t     instr,
	output logic                ack,
	output logic [`CPU_DW-1:0]  result
);

	import cpu_pkg::*;

	ctrl_t                  ctrl;
	logic [`CPU_CW-1:0]     imm;
	logic [`CPU_DW-1:0]     bus;
	logic [`CPU_DW-1:0]     rd_data;
	logic [`CPU_DW-1:0]     hi;
	logic [`CPU_DW-1:0]     lo;
	logic [`CPU_DW-1:0]     y;
	logic [2*`CPU_DW-1:0]   z;
	logic [2*`CPU_DW-1:0]   alu_res;

	control_unit u_ctrl (.clk(clk), .rst_n(rst_n), .req(req), .instr(instr),
		.ack(ack), .ctrl(ctrl), .imm(imm));

	reg_file u_rf (.clk(clk), .rst_n(rst_n), .ctrl(ctrl), .bus(bus), .z(z),
		.rd_data(rd_data), .hi(hi), .lo(lo));

	bus_select u_bus (.ctrl(ctrl), .rd_data(rd_data), .hi(hi), .lo(lo),
		.z_lo(z[`CPU_DW-1:0]), .imm(imm), .bus(bus));

	alu u_alu (.op(ctrl.alu_op), .a(y), .b(bus), .result(alu_res));

	// Y and Z hold operands between steps
	always_ff @(posedge clk) begin
		if (ctrl.y_en) begin
			y <= bus;
		end
		if (ctrl.z_en) begin
			z <= alu_res;
		end
	end

	// Writeback value returned to the host, held through ack
	always_ff @(posedge clk) begin
		if (ctrl.gen_we) begin
			result <= bus;
		end
	end

endmodule

/* logic/control_unit.sv */
// Control unit: host handshake, instruction register and step sequencer driving the datapath
`timescale 1ns/1ps
`include "cpu_consts.svh"

module control_unit (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                req,
	input  cpu_pkg::instr_t     instr,
	output logic                ack,
	output cpu_pkg::ctrl_t      ctrl,
	output logic [`CPU_CW-1:0]  imm
);

	import cpu_pkg::*;

	instr_t                 ir;
	logic [`CPU_NSTEP-1:0]  step;
	logic                   start;
	logic                   is_mf;
	logic                   is_imm;

	// Accept only when idle and the previous ack has dropped
	assign start = req && !ack && (step == '0);

	// One-hot steps: Y load, Z load, writeback, ack
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			step <= '0;
			ack  <= 1'b0;
		end else begin
			if (start) begin
				step <= {{(`CPU_NSTEP-1){1'b0}}, 1'b1};
			end else begin
				step <= step << 1;
			end
			if (step[`CPU_NSTEP-1]) begin
				ack <= 1'b1;
			end else if (!req) begin
				ack <= 1'b0;
			end
		end
	end

	// Instruction register
	always_ff @(posedge clk) begin
		if (start) begin
			ir <= instr;
		end
	end

	assign imm = ir.i.c;

	assign is_mf  = (ir.r.opcode == `OP_MFHI) || (ir.r.opcode == `OP_MFLO);
	assign is_imm = (ir.r.opcode == `OP_ADDI) || (ir.r.opcode == `OP_ANDI) ||
		(ir.r.opcode == `OP_ORI);

	// Control word per step
	always_comb begin
		ctrl         = '0;
		ctrl.bus_src = BUS_REG;
		ctrl.alu_op  = ir.r.opcode;
		ctrl.wr_idx  = ir.r.ra;

		// Y <= rb, skipped for the HI/LO moves
		if (step[0] && !is_mf) begin
			ctrl.rd_idx = ir.r.rb;
			ctrl.y_en   = 1'b1;
		end

		// Z <= Y op (rc or constant)
		if (step[1] && !is_mf) begin
			ctrl.rd_idx = ir.r.rc;
			ctrl.z_en   = 1'b1;
			if (is_imm) begin
				ctrl.bus_src = BUS_IMM;
			end
		end

		if (step[2]) begin
			ctrl.gen_we = 1'b1;
			if (ir.r.opcode == `OP_MFHI) begin
				ctrl.bus_src = BUS_HI;
			end else if (ir.r.opcode == `OP_MFLO) begin
				ctrl.bus_src = BUS_LO;
			end else begin
				ctrl.bus_src = BUS_ZLO;
			end
			// mul also latches both product halves
			if (ir.r.opcode == `OP_MUL) begin
				ctrl.hi_en = 1'b1;
				ctrl.lo_en = 1'b1;
			end
		end
	end

	// Host may not drop req before it has seen ack
	a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> req)
		else $error("control_unit: ack rose while req was low");

	// Y, Z and register writes never overlap
	a_one_we: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({ctrl.y_en, ctrl.z_en, ctrl.gen_we}))
		else $error("control_unit: conflicting write enables");

endmodule

/* logic/bus_select.sv */
// Bus multiplexer: picks the source of the shared bus and sign-extends the constant
`timescale 1ns/1ps
`include "cpu_consts.svh"

module bus_select (
	input  cpu_pkg::ctrl_t      ctrl,
	input  logic [`CPU_DW-1:0]  rd_data,
	input  logic [`CPU_DW-1:0]  hi,
	input  logic [`CPU_DW-1:0]  lo,
	input  logic [`CPU_DW-1:0]  z_lo,
	input  logic [`CPU_CW-1:0]  imm,
	output logic [`CPU_DW-1:0]  bus
);

	import cpu_pkg::*;

	logic [`CPU_DW-1:0] imm_ext;

	// Constant is signed, top bit copied upward
	assign imm_ext = {{(`CPU_DW-`CPU_CW){imm[`CPU_CW-1]}}, imm};

	always_comb begin
		unique case (ctrl.bus_src)
			BUS_REG: bus = rd_data;
			BUS_HI:  bus = hi;
			BUS_LO:  bus = lo;
			BUS_ZLO: bus = z_lo;
			BUS_IMM: bus = imm_ext;
			default: bus = '0;
		endcase
	end

	// Control word from the sequencer never carries an undefined source
	always_comb begin
		a_src_valid: assert (ctrl.bus_src inside {BUS_REG, BUS_HI, BUS_LO, BUS_ZLO, BUS_IMM})
			else $error("bus_select: undefined bus source %0d", ctrl.bus_src);
	end

endmodule

/* logic/reg_file.sv */
// Register file: sixteen general registers written from the bus, HI and LO from Z
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cpu_pkg::ctrl_t        ctrl,
	input  logic [`CPU_DW-1:0]    bus,
	input  logic [2*`CPU_DW-1:0]  z,
	output logic [`CPU_DW-1:0]    rd_data,
	output logic [`CPU_DW-1:0]    hi,
	output logic [`CPU_DW-1:0]    lo
);

	logic [`CPU_DW-1:0] regs [`CPU_NREG];

	// General registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.gen_we) begin
			regs[ctrl.wr_idx] <= bus;
		end
	end

	// HI and LO take the product halves straight from Z
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hi <= '0;
			lo <= '0;
		end else begin
			if (ctrl.hi_en) begin
				hi <= z[2*`CPU_DW-1:`CPU_DW];
			end
			if (ctrl.lo_en) begin
				lo <= z[`CPU_DW-1:0];
			end
		end
	end

	// Single read port
	assign rd_data = regs[ctrl.rd_idx];

endmodule

/* logic/alu.sv */
// ALU: combines Y and the bus into a 64-bit result for the Z register
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu (
	input  logic [`CPU_OPW-1:0]   op,
	input  logic [`CPU_DW-1:0]    a,
	input  logic [`CPU_DW-1:0]    b,
	output logic [2*`CPU_DW-1:0]  result
);

	logic [2*`CPU_DW-1:0] product;

	// Both operands signed, so the 64-bit context sign-extends them
	assign product = $signed(a) * $signed(b);

	always_comb begin
		result = '0;
		case (op)
			`OP_ADD, `OP_ADDI: begin
				result[`CPU_DW-1:0] = a + b;
			end
			`OP_SUB: begin
				result[`CPU_DW-1:0] = a - b;
			end
			`OP_AND, `OP_ANDI: begin
				result[`CPU_DW-1:0] = a & b;
			end
			`OP_OR, `OP_ORI: begin
				result[`CPU_DW-1:0] = a | b;
			end
			// Shift amount is the low five bits of the bus
			`OP_SHL: begin
				result[`CPU_DW-1:0] = a << b[4:0];
			end
			`OP_SHR: begin
				result[`CPU_DW-1:0] = a >> b[4:0];
			end
			// Unary ops ignore Y
			`OP_NEG: begin
				result[`CPU_DW-1:0] = -b;
			end
			`OP_NOT: begin
				result[`CPU_DW-1:0] = ~b;
			end
			`OP_MUL: begin
				result = product;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

/* logic/cpu_pkg.sv */
// Core types: instruction word views, bus source codes and the control word
`include "cpu_consts.svh"

package cpu_pkg;

	// Register format: ra <= rb op rc
	typedef struct packed {
		logic [`CPU_OPW-1:0] opcode;
		logic [`CPU_RW-1:0]  ra;
		logic [`CPU_RW-1:0]  rb;
		logic [`CPU_RW-1:0]  rc;
		logic [14:0]         spare;
	} instr_r_t;

	// Immediate format: ra <= rb op sext(c)
	typedef struct packed {
		logic [`CPU_OPW-1:0] opcode;
		logic [`CPU_RW-1:0]  ra;
		logic [`CPU_RW-1:0]  rb;
		logic [`CPU_CW-1:0]  c;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_t;

	typedef enum logic [2:0] {
		BUS_REG = 3'd0,
		BUS_HI  = 3'd1,
		BUS_LO  = 3'd2,
		BUS_ZLO = 3'd3,
		BUS_IMM = 3'd4
	} bus_src_e;

	typedef struct packed {
		bus_src_e            bus_src;
		logic [`CPU_RW-1:0]  rd_idx;
		logic [`CPU_OPW-1:0] alu_op;
		logic                y_en;
		logic                z_en;
		logic                gen_we;
		logic [`CPU_RW-1:0]  wr_idx;
		logic                hi_en;
		logic                lo_en;
	} ctrl_t;

endpackage

/* logic/cpu_consts.svh */
// Core constants: datapath widths, register count, step count and opcode codes
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and field widths
`define CPU_DW    32
`define CPU_NREG  16
`define CPU_RW    4
`define CPU_OPW   5
`define CPU_CW    19

// Steps after the instruction register loads: Y, Z, writeback, ack
`define CPU_NSTEP 4

// Opcodes
`define OP_ADD    5'd0
`define OP_SUB    5'd1
`define OP_AND    5'd2
`define OP_OR     5'd3
`define OP_SHL    5'd4
`define OP_SHR    5'd5
`define OP_NEG    5'd6
`define OP_NOT    5'd7
`define OP_MUL    5'd8
`define OP_ADDI   5'd9
`define OP_ANDI   5'd10
`define OP_ORI    5'd11
`define OP_MFHI   5'd12
`define OP_MFLO   5'd13

`endif
